// File: compile.f
+incdir+source
source/sens_io_pkg.sv
source/sens_cmd_deser.sv
source/sens_ctrl_regs.sv
source/sens_status_gen.sv
source/sens_io_top.sv
verif/sens_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sensor I/O testbench with Verilator, log in sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sens_io_tb -f compile.f -o sens_io_sim

./obj_dir/sens_io_sim > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

// File: verif/sens_io_tb.sv
/* directed testbench for sens_io_top with a single 40 ns clock and inputs driven on the falling edge.
   expected pads and packets come from a small model of the control and status fields */
`timescale 1ns/1ps
`include "sens_io_macros.svh"

module sens_io_tb
    import sens_io_pkg::*;
();

    logic       pclk;
    logic       rst;                    // async_prst_with_sens_mrst
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic [7:0] status_ad;
    logic       status_rq;
    logic       status_start;
    logic       ext_sync, dvalid, perr, pll_locked, sens_pgm;
    logic [3:0] gp_in;
    gp_pads_t   gp_pads;
    logic       sens_mrst_oe, rst_mmcm;
    integer     seed = 32'hf087;        // fixed stimulus seed
    integer     errors = 0;
    integer     checks = 0;
    logic [1:0] m_mode [4];             // model of stored GP modes
    logic       m_mrst_n, m_rst, m_hact, m_perr;
    logic [5:0] m_seq;                  // seq of last status write

    sens_io_top UUT (
        .pclk_i (pclk), .async_prst_with_sens_mrst_i (rst),
        .cmd_ad_i (cmd_ad), .cmd_stb_i (cmd_stb),
        .status_ad_o (status_ad), .status_rq_o (status_rq), .status_start_i (status_start),
        .ext_sync_i (ext_sync), .dvalid_i (dvalid), .perr_i (perr),
        .pll_locked_i (pll_locked), .sens_pgm_i (sens_pgm), .gp_in_i (gp_in),
        .gp_pads_o (gp_pads), .sens_mrst_oe_o (sens_mrst_oe), .rst_mmcm_o (rst_mmcm)
    );

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    function automatic logic [10:0] addr_of(input logic [2:0] idx);
        logic [10:0] a;
        a = `SENSIO_ADDR;
        a[2:0] = idx;                   // base has idx bits clear
        return a;
    endfunction

    // value/enable rule plus the flag clear of every control write
    task automatic apply_ctrl(input logic [31:0] d);
        if (d[`SENS_CTRL_MRST + 1]) m_mrst_n = d[`SENS_CTRL_MRST];
        if (d[`SENS_CTRL_RST_MMCM + 1]) m_rst = d[`SENS_CTRL_RST_MMCM];
        for (int i = 0; i < 4; i++) begin
            if (d[`SENS_CTRL_GP0 + 3*i + 2]) m_mode[i] = d[`SENS_CTRL_GP0 + 3*i +: 2];
        end
        m_hact = 1'b0;
        m_perr = 1'b0;
    endtask

    // sends six bytes back-to-back and with settle returns 2 edges after D3
    task automatic write_reg(input logic [10:0] addr, input logic [31:0] data, input bit settle);
        @(negedge pclk);
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];            // AL
        @(negedge pclk);
        cmd_stb = 1'b0;
        cmd_ad  = {5'd0, addr[10:8]};   // AH
        for (int i = 0; i < 4; i++) begin
            @(negedge pclk);
            cmd_ad = data[8*i +: 8];    // D0 first
        end
        if (settle) begin
            @(negedge pclk);
            cmd_ad = 8'd0;
            repeat (2) @(negedge pclk);
        end
    endtask

    task automatic write_ctrl(input logic [31:0] data);
        write_reg(addr_of(`SENSIO_CTRL), data, 1'b1);
        apply_ctrl(data);
    endtask

    task automatic check_outputs();
        logic [3:0] oe;
        logic [3:0] out;
        for (int i = 0; i < 4; i++) begin
            oe[i]  = (m_mode[i] != GP_FLOAT);
            out[i] = (m_mode[i] == GP_HIGH) || (m_mode[i] == GP_TRIGGER && ext_sync);
        end
        check_val("gp_pads_o.oe", 32'(oe), 32'(gp_pads.oe));
        check_val("gp_pads_o.out", 32'(out), 32'(gp_pads.out & oe));  // driven pins only
        check_val("sens_mrst_oe_o", 32'(!m_mrst_n), 32'(sens_mrst_oe));
        check_val("rst_mmcm_o", 32'(m_rst), 32'(rst_mmcm));
    endtask

    // waits for rq and withholds start for hold cycles before checking all 4 bytes
    task automatic expect_packet(input int hold);
        logic [7:0]  b [4];
        logic [17:0] p;
        int          t;
        t = 0;
        while (!status_rq && t < 200) begin
            @(negedge pclk);
            t++;
        end
        assert (status_rq) else report("timed out waiting for status_rq_o");
        if (status_rq) begin
            repeat (hold) begin
                @(negedge pclk);
                assert (status_rq) else report("status_rq_o dropped while start withheld");
            end
            b[0] = status_ad;
            status_start = 1'b1;
            @(negedge pclk);
            assert (!status_rq) else report("status_rq_o still high after start");
            status_start = 1'b0;
            for (int i = 1; i < 4; i++) begin
                b[i] = status_ad;
                @(negedge pclk);
            end
            p = {m_mode[3], m_mode[2], m_mode[1], m_mode[0], gp_in, sens_pgm, pll_locked,
                 m_hact, m_perr, m_mrst_n, m_rst};
            check_val("status byte 0", 32'(`SENSIO_STATUS_REG), 32'(b[0]));
            check_val("status byte 1", 32'({m_seq, p[1:0]}), 32'(b[1]));
            check_val("status byte 2", 32'(p[9:2]), 32'(b[2]));
            check_val("status byte 3", 32'(p[17:10]), 32'(b[3]));
        end
    endtask

    task automatic no_packet(input int cycles);
        logic seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge pclk);
            seen = seen | status_rq;
        end
        assert (!seen) else report("unexpected status packet request");
    endtask

    task automatic reset_and_gp_modes();
        logic [31:0] d;
        check_outputs();
        check_val("status_rq_o", 32'd0, 32'(status_rq));
        for (int n = 0; n < 9; n++) begin
            d = $random(seed);
            if (n == 8) d = 32'h00ff_f000;  // all pins trigger
            write_ctrl(d);
            check_outputs();
            repeat (2) begin
                ext_sync = ~ext_sync;
                @(negedge pclk);
                check_outputs();
            end
        end
    endtask

    task automatic address_decode();
        logic [31:0] d;
        logic [10:0] a;
        for (int n = 0; n < 10; n++) begin
            d = $random(seed);
            a = d[26:16];
            if (((a ^ `SENSIO_ADDR) & `SENSIO_ADDR_MASK) == 11'd0) a[3] = ~a[3];  // force miss
            if (n >= 4) a = addr_of(3'(n - 2));  // unused indices 2..7
            write_reg(a, d | 32'h0092_4082, 1'b1);  // every enable set
            check_outputs();
        end
        no_packet(8);
        d = 32'h0000_0082;                  // flip both reset fields
        d[`SENS_CTRL_MRST] = ~m_mrst_n;
        d[`SENS_CTRL_RST_MMCM] = ~m_rst;
        write_reg(addr_of(`SENSIO_CTRL), d, 1'b0);
        apply_ctrl(d);
        d = $random(seed);
        d = d & 32'h00ff_f000;              // second one GP fields only
        write_reg(addr_of(`SENSIO_CTRL), d, 1'b1);
        apply_ctrl(d);
        check_outputs();
    endtask

    task automatic reset_fields();
        logic [31:0] words [7] = '{32'h03, 32'h00, 32'hc0, 32'h00, 32'h80, 32'h02, 32'h03};
        foreach (words[i]) begin
            write_ctrl(words[i]);           // 0 enables nothing so fields must hold
            check_outputs();
        end
    endtask

    task automatic single_packet();
        logic [31:0] r;
        r = $random(seed);
        m_seq      = r[5:0];
        sens_pgm   = r[8];
        pll_locked = r[9];
        gp_in      = r[15:12];
        write_reg(addr_of(`SENSIO_STATUS), {24'd0, m_seq, ST_ONCE}, 1'b1);
        expect_packet(0);
        gp_in = ~gp_in;                     // payload change that off mode must ignore
        no_packet(20);                      // once mode falls back to off
    endtask

    task automatic sticky_flags();
        dvalid = 1'b1;
        perr   = 1'b1;
        @(negedge pclk);
        dvalid = 1'b0;
        perr   = 1'b0;
        m_hact = 1'b1;
        m_perr = 1'b1;
        write_reg(addr_of(`SENSIO_STATUS), {24'd0, m_seq, ST_ONCE}, 1'b1);
        expect_packet(2);
        write_ctrl(32'd0);                  // clears both flags
        write_reg(addr_of(`SENSIO_STATUS), {24'd0, m_seq, ST_ONCE}, 1'b1);
        expect_packet(0);
    endtask

    task automatic auto_mode_backpressure();
        write_reg(addr_of(`SENSIO_STATUS), {24'd0, m_seq, ST_AUTO}, 1'b1);
        no_packet(10);                      // payload same as last packet
        gp_in = gp_in ^ 4'h9;
        expect_packet(6);
        no_packet(20);
    endtask

    initial begin
        rst          = 1'b1;
        cmd_ad       = 8'd0;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        ext_sync     = 1'b0;
        dvalid       = 1'b0;
        perr         = 1'b0;
        pll_locked   = 1'b0;
        sens_pgm     = 1'b0;
        gp_in        = 4'd0;
        m_mode       = '{2'd0, 2'd0, 2'd0, 2'd0};
        m_mrst_n     = 1'b0;
        m_rst        = 1'b0;
        m_hact       = 1'b0;
        m_perr       = 1'b0;
        m_seq        = 6'd0;
        repeat (10) @(negedge pclk);
        rst = 1'b0;
        @(negedge pclk);
        reset_and_gp_modes();
        address_decode();
        reset_fields();
        single_packet();
        sticky_flags();
        auto_mode_backpressure();
        repeat (4) @(negedge pclk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/sens_io_top.sv
/* sensor I/O control top, single pclk domain.
   reset input is expected to already include the sensor and PLL resets */
`timescale 1ns/1ps

module sens_io_top
    import sens_io_pkg::*;
(
    input  logic       pclk_i,
    input  logic       async_prst_with_sens_mrst_i,
    input  logic [7:0] cmd_ad_i,
    input  logic       cmd_stb_i,
    output logic [7:0] status_ad_o,
    output logic       status_rq_o,
    input  logic       status_start_i,
    input  logic       ext_sync_i,
    input  logic       dvalid_i,
    input  logic       perr_i,
    input  logic       pll_locked_i,
    input  logic       sens_pgm_i,      // board detect
    input  logic [3:0] gp_in_i,         // GP pad readback
    output gp_pads_t   gp_pads_o,
    output logic       sens_mrst_oe_o,
    output logic       rst_mmcm_o
);

    sens_cmd_t      cmd;
    gp_mode_e [3:0] gp_mode;
    logic           sens_mrst_n;
    logic           hact_alive;
    logic           perr_persistent;
    sens_status_t   payload;

    assign payload = '{gp_mode: gp_mode, gp_in: gp_in_i, sens_pgm: sens_pgm_i,
                       pll_locked: pll_locked_i, hact_alive: hact_alive,
                       perr_persistent: perr_persistent, sens_mrst_n: sens_mrst_n,
                       rst_mmcm: rst_mmcm_o};

    sens_cmd_deser u_deser (
        .pclk_i, .async_prst_with_sens_mrst_i,
        .cmd_ad_i, .cmd_stb_i,
        .cmd_o (cmd)
    );

    sens_ctrl_regs u_ctrl (
        .pclk_i, .async_prst_with_sens_mrst_i,
        .cmd_i (cmd),
        .ext_sync_i, .dvalid_i, .perr_i,
        .gp_mode_o (gp_mode),
        .gp_pads_o, .sens_mrst_oe_o, .rst_mmcm_o,
        .sens_mrst_n_o (sens_mrst_n),
        .hact_alive_o (hact_alive),
        .perr_persistent_o (perr_persistent)
    );

    sens_status_gen u_status (
        .pclk_i, .async_prst_with_sens_mrst_i,
        .cmd_i (cmd),
        .payload_i (payload),
        .status_ad_o, .status_rq_o, .status_start_i
    );

endmodule

// File: source/sens_status_gen.sv
/* status packet source with rq/start handshake and 3 payload bytes back-to-back.
   one packet in flight; triggers while pending or sending merge into it. seq is not advanced */
`timescale 1ns/1ps
`include "sens_io_macros.svh"

module sens_status_gen
    import sens_io_pkg::*;
(
    input  logic         pclk_i,
    input  logic         async_prst_with_sens_mrst_i,
    input  sens_cmd_t    cmd_i,
    input  sens_status_t payload_i,
    output logic [7:0]   status_ad_o,
    output logic         status_rq_o,     // packet pending
    input  logic         status_start_i   // acknowledges byte 0
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_REQ  = 2'd1,  // waiting for start
        S_SEND = 2'd2   // bytes 1..3
    } state_e;

    state_e                          state;
    status_mode_e                    mode;
    status_mode_e                    wr_mode;
    logic [5:0]                      seq;
    logic [1:0]                      bcnt;      // byte being sent and 0 outside S_SEND
    logic [`STATUS_PAYLOAD_BITS-1:0] cur;
    logic [`STATUS_PAYLOAD_BITS-1:0] sent;      // copy captured at acknowledge
    logic                            st_wr;
    logic                            once_r;    // one shot request
    logic                            chg_r;     // auto mode change seen

    assign cur     = payload_i;
    assign st_wr   = cmd_i.we && (cmd_i.idx == `SENSIO_STATUS);
    assign wr_mode = status_mode_e'(cmd_i.data[1:0]);

    always_ff @(posedge pclk_i or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            mode   <= ST_OFF;
            seq    <= 6'd0;
            once_r <= 1'b0;
            chg_r  <= 1'b0;
        end else begin
            once_r <= st_wr && cmd_i.data[0];                         // once, once+auto
            chg_r  <= (mode == ST_AUTO) && (cur != sent);
            if (st_wr) begin
                seq <= cmd_i.data[7:2];
                case (wr_mode)
                    ST_ONCE:      mode <= ST_OFF;                     // one shot only
                    ST_ONCE_AUTO: mode <= ST_AUTO;
                    default:      mode <= wr_mode;
                endcase
            end
        end
    end

    // packet FSM
    always_ff @(posedge pclk_i or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            state <= S_IDLE;
            bcnt  <= 2'd0;
            sent  <= '0;
        end else begin
            case (state)
                S_IDLE: if (once_r || chg_r) state <= S_REQ;
                S_REQ: begin
                    if (status_start_i) begin
                        state <= S_SEND;
                        bcnt  <= 2'd1;
                        sent  <= cur;                                 // payload frozen here
                    end
                end
                S_SEND: begin
                    if (bcnt == 2'(`STATUS_BYTES - 1)) begin
                        state <= S_IDLE;
                        bcnt  <= 2'd0;
                    end else begin
                        bcnt <= bcnt + 2'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        case (bcnt)
            2'd1:    status_ad_o = {seq, sent[1:0]};
            2'd2:    status_ad_o = sent[9:2];
            2'd3:    status_ad_o = sent[17:10];
            default: status_ad_o = `SENSIO_STATUS_REG;  // byte 0 while requesting
        endcase
    end

    assign status_rq_o = (state == S_REQ);

endmodule

// File: source/sens_ctrl_regs.sv
/* control register with value/enable bit pairs, GP and sensor reset pad drive,
   sticky health flags. dvalid_i and perr_i are assumed synchronous to pclk */
`timescale 1ns/1ps
`include "sens_io_macros.svh"

module sens_ctrl_regs
    import sens_io_pkg::*;
(
    input  logic           pclk_i,
    input  logic           async_prst_with_sens_mrst_i,
    input  sens_cmd_t      cmd_i,
    input  logic           ext_sync_i,        // trigger source for GP pins
    input  logic           dvalid_i,
    input  logic           perr_i,
    output gp_mode_e [3:0] gp_mode_o,
    output gp_pads_t       gp_pads_o,
    output logic           sens_mrst_oe_o,    // 1 = pull sensor reset low
    output logic           rst_mmcm_o,
    output logic           sens_mrst_n_o,
    output logic           hact_alive_o,
    output logic           perr_persistent_o
);

    localparam int GP_POS [4] = '{`SENS_CTRL_GP0, `SENS_CTRL_GP1,
                                  `SENS_CTRL_GP2, `SENS_CTRL_GP3};

    gp_mode_e [3:0] gp_mode;
    logic           sens_mrst_n;      // 0 holds the sensor in reset
    logic           rst_mmcm;
    logic           ctrl_wr;
    logic           dvalid_r;
    logic           dvalid_rise;
    logic           hact_alive;
    logic           perr_persistent;

    assign ctrl_wr     = cmd_i.we && (cmd_i.idx == `SENSIO_CTRL);
    assign dvalid_rise = dvalid_i && !dvalid_r;

    // fields only change where their enable bit is set
    always_ff @(posedge pclk_i or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            sens_mrst_n <= 1'b0;                          // sensor held in reset
            rst_mmcm    <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                gp_mode[i] <= GP_FLOAT;
            end
        end else if (ctrl_wr) begin
            if (cmd_i.data[`SENS_CTRL_MRST + 1]) begin
                sens_mrst_n <= cmd_i.data[`SENS_CTRL_MRST];
            end
            if (cmd_i.data[`SENS_CTRL_RST_MMCM + 1]) begin
                rst_mmcm <= cmd_i.data[`SENS_CTRL_RST_MMCM];
            end
            for (int i = 0; i < 4; i++) begin
                if (cmd_i.data[GP_POS[i] + 2]) begin      // per pin enable
                    gp_mode[i] <= gp_mode_e'(cmd_i.data[GP_POS[i] +: 2]);
                end
            end
        end
    end

    // sticky flags, a set beats the clear from a control write
    always_ff @(posedge pclk_i or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            dvalid_r        <= 1'b0;
            hact_alive      <= 1'b0;
            perr_persistent <= 1'b0;
        end else begin
            dvalid_r <= dvalid_i;
            if (dvalid_rise) begin
                hact_alive <= 1'b1;
            end else if (ctrl_wr) begin
                hact_alive <= 1'b0;
            end
            if (perr_i) begin
                perr_persistent <= 1'b1;
            end else if (ctrl_wr) begin
                perr_persistent <= 1'b0;
            end
        end
    end

    // pad drive from stored modes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            gp_pads_o.oe[i] = (gp_mode[i] != GP_FLOAT);
            case (gp_mode[i])
                GP_HIGH:    gp_pads_o.out[i] = 1'b1;
                GP_TRIGGER: gp_pads_o.out[i] = ext_sync_i;
                default:    gp_pads_o.out[i] = 1'b0;  // low, or don't care when floating
            endcase
        end
    end

    assign sens_mrst_oe_o    = !sens_mrst_n;  // open drain, float when released
    assign rst_mmcm_o        = rst_mmcm;
    assign sens_mrst_n_o     = sens_mrst_n;
    assign gp_mode_o         = gp_mode;
    assign hact_alive_o      = hact_alive;
    assign perr_persistent_o = perr_persistent;

endmodule

// File: source/sens_cmd_deser.sv
/* byte-serial command input: strobe with AL, then AH D0..D3 on back-to-back cycles.
   no gaps allowed inside a command; a strobe in mid-command restarts collection */
`timescale 1ns/1ps
`include "sens_io_macros.svh"

module sens_cmd_deser
    import sens_io_pkg::*;
(
    input  logic       pclk_i,
    input  logic       async_prst_with_sens_mrst_i,
    input  logic [7:0] cmd_ad_i,   // address/data byte
    input  logic       cmd_stb_i,  // with first byte only
    output sens_cmd_t  cmd_o       // decoded write
);

    logic [2:0]  cnt;      // byte position, 0 = idle
    logic [10:0] addr_r;   // {AH[2:0], AL}
    logic [31:0] data_r;   // D0 ends up in [7:0]
    logic        done_r;   // D3 just sampled
    logic        match;    // address in our window
    logic        we_r;
    logic [2:0]  idx_r;
    logic [31:0] wdata_r;

    assign match = (addr_r & `SENSIO_ADDR_MASK) == (`SENSIO_ADDR & `SENSIO_ADDR_MASK);

    always_ff @(posedge pclk_i or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            cnt    <= 3'd0;
            done_r <= 1'b0;
            we_r   <= 1'b0;
        end else begin
            done_r <= !cmd_stb_i && (cnt == 3'(`CMD_BYTES - 1));  // last byte in
            we_r   <= done_r && match;                           // one cycle write
            if (cmd_stb_i) begin
                cnt <= 3'd1;                                     // AL taken now
            end else if (cnt == 3'(`CMD_BYTES - 1)) begin
                cnt <= 3'd0;                                     // command complete
            end else if (cnt != 3'd0) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // byte capture, payload only
    always_ff @(posedge pclk_i) begin
        if (cmd_stb_i) begin
            addr_r[7:0] <= cmd_ad_i;                  // AL
        end else if (cnt == 3'd1) begin
            addr_r[10:8] <= cmd_ad_i[2:0];            // AH, upper bits unused
        end else if (cnt != 3'd0) begin
            data_r <= {cmd_ad_i, data_r[31:8]};       // D0 first, shifts down
        end
        if (done_r) begin
            idx_r   <= addr_r[2:0];                   // held while next cmd loads
            wdata_r <= data_r;
        end
    end

    assign cmd_o = '{we: we_r, idx: idx_r, data: wdata_r};

endmodule

// File: source/sens_io_pkg.sv
/* shared types of the sensor I/O block.
   sens_status_t width must stay equal to STATUS_PAYLOAD_BITS */
package sens_io_pkg;

    // GP pin mode, 2 bits per pin
    typedef enum logic [1:0] {
        GP_FLOAT   = 2'd0,  // pad released
        GP_LOW     = 2'd1,  // driven 0
        GP_HIGH    = 2'd2,  // driven 1
        GP_TRIGGER = 2'd3   // follows ext sync
    } gp_mode_e;

    // status packet mode, from data[1:0] of a status write
    typedef enum logic [1:0] {
        ST_OFF       = 2'd0,
        ST_ONCE      = 2'd1,  // single packet, then off
        ST_AUTO      = 2'd2,  // packet on every payload change
        ST_ONCE_AUTO = 2'd3   // single packet, then auto
    } status_mode_e;

    // one decoded register write
    typedef struct packed {
        logic        we;    // single cycle strobe
        logic [2:0]  idx;   // register index
        logic [31:0] data;
    } sens_cmd_t;

    // GP pad drive
    typedef struct packed {
        logic [3:0] oe;   // 1 = driven
        logic [3:0] out;  // value when driven
    } gp_pads_t;

    // status payload, MSB first
    typedef struct packed {
        gp_mode_e [3:0] gp_mode;
        logic [3:0]     gp_in;
        logic           sens_pgm;         // sensor board present
        logic           pll_locked;
        logic           hact_alive;       // sticky, dvalid seen
        logic           perr_persistent;  // sticky parity error
        logic           sens_mrst_n;
        logic           rst_mmcm;
    } sens_status_t;

endpackage

// File: source/sens_io_macros.svh
/* address map, control field positions and packet sizes of the sensor I/O block.
   reset and GP fields need their enable bit set in the same write to take effect */
`ifndef SENS_IO_MACROS_SVH
`define SENS_IO_MACROS_SVH

// command decode
`define SENSIO_ADDR        11'h330  // base of this block
`define SENSIO_ADDR_MASK   11'h7f8  // 8 register slots
`define SENSIO_CTRL        3'h0     // control register index
`define SENSIO_STATUS      3'h1     // status mode / seq index

// first byte of every status packet
`define SENSIO_STATUS_REG  8'h21

// control word, lowest bit of each field
`define SENS_CTRL_MRST     0   // value at 0, enable at 1
`define SENS_CTRL_RST_MMCM 6   // value at 6, enable at 7
`define SENS_CTRL_GP0      12  // mode 13:12, enable 14
`define SENS_CTRL_GP1      15  // mode 16:15, enable 17
`define SENS_CTRL_GP2      18  // mode 19:18, enable 20
`define SENS_CTRL_GP3      21  // mode 22:21, enable 23

// byte-serial framing
`define CMD_BYTES           6   // AL AH D0 D1 D2 D3
`define STATUS_PAYLOAD_BITS 18  // must match sens_status_t
`define STATUS_BYTES        4   // addr + 3 payload bytes

`endif
